// File: Bender.yml
package:
  name: inbound_read

sources:
  - files:
      - hw/pcie_rd_pkg.sv
      - hw/axi_rd_pkg.sv
      - hw/rd_fifo.sv
      - hw/rd_cmd_split.sv
      - hw/rd_credit_ctrl.sv
      - hw/rd_resp_fsm.sv
      - hw/inbound_read.sv
  - target: test
    files:
      - tests/axi_slave_model.sv
      - tests/tb_inbound_read.sv

// File: all.f
hw/pcie_rd_pkg.sv
hw/axi_rd_pkg.sv
hw/rd_fifo.sv
hw/rd_cmd_split.sv
hw/rd_credit_ctrl.sv
hw/rd_resp_fsm.sv
hw/inbound_read.sv
tests/axi_slave_model.sv
tests/tb_inbound_read.sv

// File: hw/axi_rd_pkg.sv
package axi_rd_pkg;

    localparam int AXI_LEN_W = 4;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_RESP_W = 2;

    localparam logic [AXI_RESP_W-1:0] RESP_OKAY = 2'b00;
    localparam logic [AXI_RESP_W-1:0] RESP_SLVERR = 2'b10;
    localparam logic [AXI_RESP_W-1:0] RESP_DECERR = 2'b11;

    // Latest error replaces whatever was collected so far
    function automatic logic [AXI_RESP_W-1:0] resp_merge(
        input logic [AXI_RESP_W-1:0] acc,
        input logic [AXI_RESP_W-1:0] resp
    );
        return (resp != RESP_OKAY) ? resp : acc;
    endfunction

endpackage

// File: hw/inbound_read.sv
`timescale 1ns/10ps

module inbound_read
    import pcie_rd_pkg::*;
    import axi_rd_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    output logic                  req_h_ready,
    input  logic                  req_h_valid,
    input  logic [ADDR_W-1:0]     req_h_addr,
    input  logic [LEN_W-1:0]      req_h_len,
    input  logic                  axi_ar_ready,
    output logic                  axi_ar_valid,
    output logic [ADDR_W-1:0]     axi_ar_addr,
    output logic [AXI_LEN_W-1:0]  axi_ar_len,
    output logic                  axi_r_ready,
    input  logic                  axi_r_valid,
    input  logic [AXI_DATA_W-1:0] axi_r_data,
    input  logic [AXI_RESP_W-1:0] axi_r_resp,
    input  logic                  axi_r_last,
    input  logic                  cpl_h_ready,
    output logic                  cpl_h_valid,
    output logic [LADDR_W-1:0]    cpl_h_addr,
    output logic [LEN_W-1:0]      cpl_h_len,
    output logic [BYTES_W-1:0]    cpl_h_bytes,
    output logic                  cpl_h_last,
    output logic [AXI_RESP_W-1:0] cpl_h_resp,
    input  logic                  cpl_d_ready,
    output logic                  cpl_d_valid,
    output logic [AXI_DATA_W-1:0] cpl_d_data,
    output logic                  cpl_d_last,
    output logic                  rd_busy
);

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
    } req_t;

    typedef struct packed {
        logic                  last;
        logic [AXI_DATA_W-1:0] data;
    } beat_t;

    logic                   req_full;
    logic                   split_ready;
    logic                   split_valid;
    req_t                   split_req;
    logic                   grant;
    logic                   cmd_fire;
    logic [BURST_LEN_W-1:0] cmd_len;
    burst_info_t            cmd_info;
    logic                   info_ready;
    logic                   info_valid;
    burst_info_t            info;
    logic                   beat_push;
    logic                   beat_last;
    beat_t                  beat_out;
    logic                   hdr_afull;
    logic                   hdr_push;
    cpl_hdr_t               hdr_in;
    cpl_hdr_t               hdr_out;
    logic                   data_pop;
    logic                   burst_done;

    assign req_h_ready = !req_full;
    assign data_pop = cpl_d_ready && cpl_d_valid;
    assign burst_done = axi_r_valid && axi_r_ready && axi_r_last;

    assign cpl_d_data = beat_out.data;
    assign cpl_d_last = beat_out.last;
    assign cpl_h_addr = hdr_out.info.addr;
    assign cpl_h_len = LEN_W'(hdr_out.info.len);
    assign cpl_h_bytes = hdr_out.info.bytes;
    assign cpl_h_last = hdr_out.info.last;
    assign cpl_h_resp = hdr_out.resp;

    rd_fifo #(
        .payload_t   (req_t),
        .DEPTH       (REQ_FIFO_DEPTH),
        .AF_LEVEL    (1)
    ) i_req_fifo (
        .clk         (clk),
        .rst         (rst),
        .push        (req_h_valid && req_h_ready),
        .wr_data     ('{addr: req_h_addr, len: req_h_len}),
        .full        (req_full),
        .almost_full (),
        .rd_ready    (split_ready),
        .rd_valid    (split_valid),
        .rd_data     (split_req)
    );

    rd_cmd_split i_cmd_split (
        .clk          (clk),
        .rst          (rst),
        .in_ready     (split_ready),
        .in_valid     (split_valid),
        .in_addr      (split_req.addr),
        .in_len       (split_req.len),
        .grant        (grant),
        .cmd_fire     (cmd_fire),
        .cmd_len      (cmd_len),
        .info         (cmd_info),
        .axi_ar_ready (axi_ar_ready),
        .axi_ar_valid (axi_ar_valid),
        .axi_ar_addr  (axi_ar_addr),
        .axi_ar_len   (axi_ar_len)
    );

    rd_credit_ctrl i_credit_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cmd_fire   (cmd_fire),
        .cmd_len    (cmd_len),
        .data_pop   (data_pop),
        .burst_done (burst_done),
        .grant      (grant),
        .rd_busy    (rd_busy)
    );

    rd_fifo #(
        .payload_t   (burst_info_t),
        .DEPTH       (MOT_MAX),
        .AF_LEVEL    (1)
    ) i_info_fifo (
        .clk         (clk),
        .rst         (rst),
        .push        (cmd_fire),
        .wr_data     (cmd_info),
        .full        (),
        .almost_full (),
        .rd_ready    (info_ready),
        .rd_valid    (info_valid),
        .rd_data     (info)
    );

    rd_resp_fsm i_resp_fsm (
        .clk         (clk),
        .rst         (rst),
        .info_valid  (info_valid),
        .info        (info),
        .info_ready  (info_ready),
        .axi_r_valid (axi_r_valid),
        .axi_r_resp  (axi_r_resp),
        .axi_r_last  (axi_r_last),
        .axi_r_ready (axi_r_ready),
        .beat_push   (beat_push),
        .beat_last   (beat_last),
        .hdr_afull   (hdr_afull),
        .hdr_push    (hdr_push),
        .hdr         (hdr_in)
    );

    // Space here was reserved at AR issue
    rd_fifo #(
        .payload_t   (beat_t),
        .DEPTH       (BUF_DW),
        .AF_LEVEL    (1)
    ) i_data_fifo (
        .clk         (clk),
        .rst         (rst),
        .push        (beat_push),
        .wr_data     ('{last: beat_last, data: axi_r_data}),
        .full        (),
        .almost_full (),
        .rd_ready    (cpl_d_ready),
        .rd_valid    (cpl_d_valid),
        .rd_data     (beat_out)
    );

    rd_fifo #(
        .payload_t   (cpl_hdr_t),
        .DEPTH       (HDR_FIFO_DEPTH),
        .AF_LEVEL    (1)
    ) i_hdr_fifo (
        .clk         (clk),
        .rst         (rst),
        .push        (hdr_push),
        .wr_data     (hdr_in),
        .full        (),
        .almost_full (hdr_afull),
        .rd_ready    (cpl_h_ready),
        .rd_valid    (cpl_h_valid),
        .rd_data     (hdr_out)
    );

endmodule

// File: hw/pcie_rd_pkg.sv
package pcie_rd_pkg;

    // Request side
    localparam int ADDR_W = 32;
    localparam int LEN_W = 10;

    // Completion header field widths
    localparam int LADDR_W = 7;
    localparam int BURST_LEN_W = 5;
    localparam int BYTES_W = 12;

    // Buffering and burst limits
    localparam int BUF_DW = 64;
    localparam int MAX_BURST_DW = 16;
    localparam int BOUND_B = 64;
    localparam int MOT_MAX = 4;
    localparam int REQ_FIFO_DEPTH = 4;
    localparam int HDR_FIFO_DEPTH = 4;

    typedef struct packed {
        logic [LADDR_W-1:0]     addr;
        logic [BURST_LEN_W-1:0] len;
        logic [BYTES_W-1:0]     bytes;
        logic                   last;
    } burst_info_t;

    // Burst record plus the merged AXI response
    typedef struct packed {
        burst_info_t info;
        logic [1:0]  resp;
    } cpl_hdr_t;

endpackage

// File: hw/rd_cmd_split.sv
`timescale 1ns/10ps

module rd_cmd_split
    import pcie_rd_pkg::*;
    import axi_rd_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    output logic                   in_ready,
    input  logic                   in_valid,
    input  logic [ADDR_W-1:0]      in_addr,
    input  logic [LEN_W-1:0]       in_len,
    input  logic                   grant,
    output logic                   cmd_fire,
    output logic [BURST_LEN_W-1:0] cmd_len,
    output burst_info_t            info,
    input  logic                   axi_ar_ready,
    output logic                   axi_ar_valid,
    output logic [ADDR_W-1:0]      axi_ar_addr,
    output logic [AXI_LEN_W-1:0]   axi_ar_len
);

    localparam int BOUND_DW = BOUND_B / 4;
    localparam int BOUND_LSB = $clog2(BOUND_B);

    logic                   active;
    logic [ADDR_W-1:0]      act_addr;
    logic [LEN_W:0]         act_rem;
    logic [ADDR_W-1:0]      cur_addr;
    logic [LEN_W:0]         cur_rem;
    logic [LEN_W+2:0]       rem_bytes;
    logic [BURST_LEN_W-1:0] bound_dw;
    logic [BURST_LEN_W-1:0] rem_cap;
    logic [BURST_LEN_W-1:0] burst_len;
    logic                   cmd_final;
    logic                   ar_free;

    // Head of the request FIFO until the first burst goes out; length 0 means 1024
    assign cur_addr = active ? act_addr : {in_addr[ADDR_W-1:2], 2'b00};
    assign cur_rem = active ? act_rem : {in_len == '0, in_len};

    assign bound_dw = BURST_LEN_W'(BOUND_DW) - BURST_LEN_W'(cur_addr[BOUND_LSB-1:2]);
    assign rem_cap = (cur_rem > (LEN_W+1)'(MAX_BURST_DW)) ? BURST_LEN_W'(MAX_BURST_DW)
                                                          : BURST_LEN_W'(cur_rem);
    assign burst_len = (rem_cap < bound_dw) ? rem_cap : bound_dw;
    assign cmd_final = ((LEN_W+1)'(burst_len) == cur_rem);

    assign ar_free = !axi_ar_valid || axi_ar_ready;
    assign cmd_fire = (active || in_valid) && grant && ar_free;
    assign in_ready = cmd_fire && cmd_final;
    assign cmd_len = burst_len;

    assign rem_bytes = {cur_rem, 2'b00};
    assign info.addr = cur_addr[LADDR_W-1:0];
    assign info.len = burst_len;
    assign info.bytes = rem_bytes[BYTES_W-1:0];
    assign info.last = cmd_final;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
        end else if (cmd_fire) begin
            active <= !cmd_final;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            act_addr <= cur_addr + ADDR_W'({burst_len, 2'b00});
            act_rem <= cur_rem - (LEN_W+1)'(burst_len);
        end
    end

    // AR register
    always_ff @(posedge clk) begin
        if (rst) begin
            axi_ar_valid <= 1'b0;
        end else if (cmd_fire) begin
            axi_ar_valid <= 1'b1;
        end else if (axi_ar_ready) begin
            axi_ar_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            axi_ar_addr <= cur_addr;
            axi_ar_len <= AXI_LEN_W'(burst_len - 1'b1);
        end
    end

    // Issued bursts stay inside one 64-byte block
    a_no_cross: assert property (@(posedge clk) disable iff (rst)
        axi_ar_valid |-> ({1'b0, axi_ar_addr[BOUND_LSB-1:2]} + {1'b0, axi_ar_len})
                         < BURST_LEN_W'(BOUND_DW));

endmodule

// File: hw/rd_credit_ctrl.sv
`timescale 1ns/10ps

module rd_credit_ctrl
    import pcie_rd_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cmd_fire,
    input  logic [BURST_LEN_W-1:0] cmd_len,
    input  logic                   data_pop,
    input  logic                   burst_done,
    output logic                   grant,
    output logic                   rd_busy
);

    localparam int FREE_W = $clog2(BUF_DW + 1);
    localparam int MOT_W = $clog2(MOT_MAX + 1);

    logic [FREE_W-1:0] free_dw;
    logic [FREE_W-1:0] free_sub;
    logic [MOT_W-1:0]  out_cnt;

    assign free_sub = cmd_fire ? FREE_W'(cmd_len) : '0;

    // Room for a worst-case burst and a free outstanding slot
    assign grant = (free_dw >= FREE_W'(MAX_BURST_DW)) && (out_cnt < MOT_W'(MOT_MAX));
    assign rd_busy = (out_cnt != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            free_dw <= FREE_W'(BUF_DW);
        end else begin
            free_dw <= free_dw - free_sub + FREE_W'(data_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_cnt <= '0;
        end else begin
            case ({cmd_fire, burst_done})
                2'b10: out_cnt <= out_cnt + 1'b1;
                2'b01: out_cnt <= out_cnt - 1'b1;
                default: out_cnt <= out_cnt;
            endcase
        end
    end

    // Data leaving the buffer was always reserved by an earlier burst
    a_free_bound: assert property (@(posedge clk) disable iff (rst)
        free_dw <= FREE_W'(BUF_DW));

    // An R-last beat always belongs to an issued burst
    a_done_after_fire: assert property (@(posedge clk) disable iff (rst)
        burst_done |-> (out_cnt != '0));

endmodule

// File: hw/rd_fifo.sv
`timescale 1ns/10ps

module rd_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH = 4,
    parameter int  AF_LEVEL = 1
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t wr_data,
    output logic     full,
    output logic     almost_full,
    input  logic     rd_ready,
    output logic     rd_valid,
    output payload_t rd_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;

    assign pop = rd_ready && rd_valid;
    assign rd_valid = (count != '0);
    assign rd_data = mem[rd_ptr];
    assign full = (count == CNT_W'(DEPTH));
    assign almost_full = (count >= CNT_W'(DEPTH - AF_LEVEL));

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Writers must honour full; overflow would drop a payload
    a_no_overflow: assert property (@(posedge clk) disable iff (rst) push |-> !full);

endmodule

// File: hw/rd_resp_fsm.sv
`timescale 1ns/10ps

module rd_resp_fsm
    import pcie_rd_pkg::*;
    import axi_rd_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  info_valid,
    input  burst_info_t           info,
    output logic                  info_ready,
    input  logic                  axi_r_valid,
    input  logic [AXI_RESP_W-1:0] axi_r_resp,
    input  logic                  axi_r_last,
    output logic                  axi_r_ready,
    output logic                  beat_push,
    output logic                  beat_last,
    input  logic                  hdr_afull,
    output logic                  hdr_push,
    output cpl_hdr_t              hdr
);

    typedef enum logic [1:0] {
        IDLE,
        DATA,
        HDR
    } state_t;

    state_t                 state;
    burst_info_t            cur_info;
    logic [BURST_LEN_W-1:0] beat_cnt;
    logic [AXI_RESP_W-1:0]  resp_acc;

    // Only take a new burst when its header is sure to fit
    assign info_ready = (state == IDLE) && !hdr_afull;
    assign axi_r_ready = (state == DATA);
    assign beat_push = axi_r_valid && axi_r_ready;
    assign beat_last = ((beat_cnt + 1'b1) == cur_info.len);

    assign hdr_push = (state == HDR);
    assign hdr.info = cur_info;
    assign hdr.resp = resp_acc;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (info_valid && info_ready) begin
                        beat_cnt <= '0;
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (beat_push) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_last) begin
                            state <= HDR;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (info_valid && info_ready) begin
            cur_info <= info;
            resp_acc <= RESP_OKAY;
        end else if (beat_push) begin
            resp_acc <= resp_merge(resp_acc, axi_r_resp);
        end
    end

    // Slave burst length agrees with the split that issued it
    a_last_match: assert property (@(posedge clk) disable iff (rst)
        beat_push |-> (axi_r_last == beat_last));

endmodule

// File: tests/axi_slave_model.sv
`timescale 1ns/10ps

module axi_slave_model
    import axi_rd_pkg::*;
#(
    parameter logic [31:0] ERR_LO = 32'h0000_1000,
    parameter logic [31:0] ERR_HI = 32'h0000_10FF
) (
    input  logic                  clk,
    input  logic                  rst,
    output logic                  ar_ready,
    input  logic                  ar_valid,
    input  logic [31:0]           ar_addr,
    input  logic [AXI_LEN_W-1:0]  ar_len,
    input  logic                  r_ready,
    output logic                  r_valid,
    output logic [AXI_DATA_W-1:0] r_data,
    output logic [AXI_RESP_W-1:0] r_resp,
    output logic                  r_last
);

    logic [31:0]          addr_q [$];
    int                   beats_q [$];
    logic [31:0]          cur_addr;
    int                   beats_left;
    logic                 ar_hs;
    logic                 r_hs;
    logic                 in_rst;
    logic [31:0]          ar_addr_s;
    logic [AXI_LEN_W-1:0] ar_len_s;

    initial begin
        ar_ready = 1'b0;
        r_valid = 1'b0;
        r_data = '0;
        r_resp = RESP_OKAY;
        r_last = 1'b0;
        cur_addr = '0;
        beats_left = 0;
    end

    always @(posedge clk) begin
        ar_hs = ar_valid && ar_ready;
        r_hs = r_valid && r_ready;
        in_rst = rst;
        ar_addr_s = ar_addr;
        ar_len_s = ar_len;
        #1;
        if (in_rst) begin
            addr_q.delete();
            beats_q.delete();
            beats_left = 0;
            ar_ready = 1'b0;
            r_valid = 1'b0;
            r_last = 1'b0;
        end else begin
            if (ar_hs) begin
                addr_q.push_back(ar_addr_s);
                beats_q.push_back(int'(ar_len_s) + 1);
            end
            if (r_hs) begin
                cur_addr = cur_addr + 32'd4;
                beats_left = beats_left - 1;
            end
            if (beats_left == 0 && addr_q.size() > 0) begin
                cur_addr = addr_q.pop_front();
                beats_left = beats_q.pop_front();
            end
            // A raised beat stays until it is taken
            if (!(r_valid && !r_hs)) begin
                r_valid = (beats_left > 0) && ($urandom_range(0, 3) != 0);
            end
            r_data = cur_addr;
            r_resp = (cur_addr >= ERR_LO && cur_addr <= ERR_HI) ? RESP_SLVERR : RESP_OKAY;
            r_last = (beats_left == 1);
            ar_ready = ($urandom_range(0, 3) != 0);
        end
    end

endmodule

// File: tests/tb_inbound_read.sv
`timescale 1ns/10ps

module tb_inbound_read
    import pcie_rd_pkg::*;
    import axi_rd_pkg::*;
;

    localparam int SEED = 69708;
    localparam int RESET_CYCLES = 10;
    localparam int N_DIRECT = 4;
    localparam int N_RANDOM = 24;
    localparam int N_ERR = 6;
    localparam int N_BP = 16;
    localparam int N_STALL = 4;
    localparam int N_REQ = N_DIRECT + N_RANDOM + N_ERR + N_BP + N_STALL;
    localparam int TIMEOUT_CYCLES = 200 * N_REQ + 1000;
    localparam int STALL_HOLD = 20;
    localparam logic [31:0] ERR_LO = 32'h0000_1000;
    localparam logic [31:0] ERR_HI = 32'h0000_10FF;

    logic                  clk;
    logic                  rst;
    logic                  req_h_ready;
    logic                  req_h_valid;
    logic [ADDR_W-1:0]     req_h_addr;
    logic [LEN_W-1:0]      req_h_len;
    logic                  axi_ar_ready;
    logic                  axi_ar_valid;
    logic [ADDR_W-1:0]     axi_ar_addr;
    logic [AXI_LEN_W-1:0]  axi_ar_len;
    logic                  axi_r_ready;
    logic                  axi_r_valid;
    logic [AXI_DATA_W-1:0] axi_r_data;
    logic [AXI_RESP_W-1:0] axi_r_resp;
    logic                  axi_r_last;
    logic                  cpl_h_ready;
    logic                  cpl_h_valid;
    logic [LADDR_W-1:0]    cpl_h_addr;
    logic [LEN_W-1:0]      cpl_h_len;
    logic [BYTES_W-1:0]    cpl_h_bytes;
    logic                  cpl_h_last;
    logic [AXI_RESP_W-1:0] cpl_h_resp;
    logic                  cpl_d_ready;
    logic                  cpl_d_valid;
    logic [AXI_DATA_W-1:0] cpl_d_data;
    logic                  cpl_d_last;
    logic                  rd_busy;

    // Expected streams: data is {last, word}, header is {addr, len, bytes, last, resp}
    logic [32:0] dq [$];
    logic [31:0] hq [$];
    logic [32:0] exp_d;
    logic        exp_d_ok;
    logic [31:0] exp_h;
    logic        exp_h_ok;

    int   errors = 0;
    int   cycles = 0;
    int   reqs_sent = 0;
    int   d_checks = 0;
    int   h_checks = 0;
    int   ready_mode;
    int   ar_hs_cnt;
    int   rlast_cnt;
    int   ar_dw_cnt;
    int   pop_dw_cnt;
    int   outstanding;
    int   reserved;
    logic busy_exp;

    logic [31:0] err_addr [N_ERR] = '{32'h0FF0, 32'h10F8, 32'h1000, 32'h0FC0, 32'h1040, 32'h1100};
    int          err_len [N_ERR] = '{16, 8, 64, 64, 3, 4};

    inbound_read i_inbound_read (
        .clk          (clk),
        .rst          (rst),
        .req_h_ready  (req_h_ready),
        .req_h_valid  (req_h_valid),
        .req_h_addr   (req_h_addr),
        .req_h_len    (req_h_len),
        .axi_ar_ready (axi_ar_ready),
        .axi_ar_valid (axi_ar_valid),
        .axi_ar_addr  (axi_ar_addr),
        .axi_ar_len   (axi_ar_len),
        .axi_r_ready  (axi_r_ready),
        .axi_r_valid  (axi_r_valid),
        .axi_r_data   (axi_r_data),
        .axi_r_resp   (axi_r_resp),
        .axi_r_last   (axi_r_last),
        .cpl_h_ready  (cpl_h_ready),
        .cpl_h_valid  (cpl_h_valid),
        .cpl_h_addr   (cpl_h_addr),
        .cpl_h_len    (cpl_h_len),
        .cpl_h_bytes  (cpl_h_bytes),
        .cpl_h_last   (cpl_h_last),
        .cpl_h_resp   (cpl_h_resp),
        .cpl_d_ready  (cpl_d_ready),
        .cpl_d_valid  (cpl_d_valid),
        .cpl_d_data   (cpl_d_data),
        .cpl_d_last   (cpl_d_last),
        .rd_busy      (rd_busy)
    );

    axi_slave_model #(
        .ERR_LO (ERR_LO),
        .ERR_HI (ERR_HI)
    ) i_axi_slave (
        .clk      (clk),
        .rst      (rst),
        .ar_ready (axi_ar_ready),
        .ar_valid (axi_ar_valid),
        .ar_addr  (axi_ar_addr),
        .ar_len   (axi_ar_len),
        .r_ready  (axi_r_ready),
        .r_valid  (axi_r_valid),
        .r_data   (axi_r_data),
        .r_resp   (axi_r_resp),
        .r_last   (axi_r_last)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_mismatch(input string sig, input logic [63:0] got,
                                   input logic [63:0] exp);
        errors++;
        $display("Error at %0t: %s = 0x%0h, expected 0x%0h", $time, sig, got, exp);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("At %0t: %s", $time, what);
    endtask

    // Split rule: at most 16 dwords, never past a 64-byte boundary
    task automatic build_expected(input logic [31:0] addr, input int len);
        logic [31:0] a;
        logic [1:0]  resp;
        int          rem;
        int          n;
        int          to_bound;
        a = addr;
        rem = len;
        while (rem > 0) begin
            to_bound = (BOUND_B - int'(a % BOUND_B)) / 4;
            n = (rem > MAX_BURST_DW) ? MAX_BURST_DW : rem;
            n = (n > to_bound) ? to_bound : n;
            resp = RESP_OKAY;
            for (int i = 0; i < n; i++) begin
                if (a + 32'(4 * i) >= ERR_LO && a + 32'(4 * i) <= ERR_HI) begin
                    resp = RESP_SLVERR;
                end
                dq.push_back({i == n - 1, a + 32'(4 * i)});
            end
            hq.push_back({a[6:0], 10'(n), 12'(rem * 4), n == rem, resp});
            a = a + 32'(4 * n);
            rem = rem - n;
        end
    endtask

    task automatic send_req(input logic [31:0] addr, input int len);
        build_expected(addr, len);
        reqs_sent++;
        req_h_valid = 1'b1;
        req_h_addr = addr;
        req_h_len = 10'(len);
        @(posedge clk);
        while (!req_h_ready) begin
            @(posedge clk);
        end
        #1;
        req_h_valid = 1'b0;
    endtask

    task automatic wait_drain();
        @(negedge clk);
        while (dq.size() != 0 || hq.size() != 0 || rd_busy) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errs_before);
        end
    endtask

    // Completion ready patterns: 0 open, 1 random gaps, 2 data held off
    always @(posedge clk) begin
        int mode_now;
        mode_now = ready_mode;
        #1;
        case (mode_now)
            1: begin
                cpl_d_ready = ($urandom_range(0, 2) != 0);
                cpl_h_ready = ($urandom_range(0, 3) != 0);
            end
            2: begin
                cpl_d_ready = 1'b0;
                cpl_h_ready = 1'b1;
            end
            default: begin
                cpl_d_ready = 1'b1;
                cpl_h_ready = 1'b1;
            end
        endcase
    end

    always @(posedge clk) begin
        if (rst) begin
            ar_hs_cnt <= 0;
            rlast_cnt <= 0;
            ar_dw_cnt <= 0;
            pop_dw_cnt <= 0;
        end else begin
            if (axi_ar_valid && axi_ar_ready) begin
                ar_hs_cnt <= ar_hs_cnt + 1;
                ar_dw_cnt <= ar_dw_cnt + int'(axi_ar_len) + 1;
            end
            if (axi_r_valid && axi_r_ready && axi_r_last) begin
                rlast_cnt <= rlast_cnt + 1;
            end
            if (cpl_d_valid && cpl_d_ready) begin
                pop_dw_cnt <= pop_dw_cnt + 1;
            end
        end
    end

    // Queue heads move into plain registers for the assertions
    always @(posedge clk) begin
        if (!rst && cpl_d_valid && cpl_d_ready) begin
            d_checks++;
            if (dq.size() > 0) begin
                void'(dq.pop_front());
            end
        end
        if (!rst && cpl_h_valid && cpl_h_ready) begin
            h_checks++;
            if (hq.size() > 0) begin
                void'(hq.pop_front());
            end
        end
        exp_d_ok <= (dq.size() > 0);
        exp_d <= (dq.size() > 0) ? dq[0] : '0;
        exp_h_ok <= (hq.size() > 0);
        exp_h <= (hq.size() > 0) ? hq[0] : '0;
    end

    // AR register counts as outstanding before its handshake
    assign outstanding = ar_hs_cnt - rlast_cnt;
    assign reserved = ar_dw_cnt - pop_dw_cnt;
    assign busy_exp = (outstanding + int'(axi_ar_valid)) != 0;

    a_d_expected: assert property (@(posedge clk) disable iff (rst)
        (cpl_d_valid && cpl_d_ready) |-> exp_d_ok)
        else report_failure("completion data arrived with no data expected");

    a_d_data: assert property (@(posedge clk) disable iff (rst)
        (cpl_d_valid && cpl_d_ready && exp_d_ok) |-> (cpl_d_data == exp_d[31:0]))
        else report_mismatch("cpl_d_data", $sampled(cpl_d_data), $sampled(exp_d[31:0]));

    a_d_last: assert property (@(posedge clk) disable iff (rst)
        (cpl_d_valid && cpl_d_ready && exp_d_ok) |-> (cpl_d_last == exp_d[32]))
        else report_mismatch("cpl_d_last", $sampled(cpl_d_last), $sampled(exp_d[32]));

    a_h_expected: assert property (@(posedge clk) disable iff (rst)
        (cpl_h_valid && cpl_h_ready) |-> exp_h_ok)
        else report_failure("completion header arrived with no header expected");

    a_h_fields: assert property (@(posedge clk) disable iff (rst)
        (cpl_h_valid && cpl_h_ready && exp_h_ok)
            |-> ({cpl_h_addr, cpl_h_len, cpl_h_bytes, cpl_h_last} == exp_h[31:2]))
        else report_mismatch("cpl_h {addr,len,bytes,last}",
            $sampled({cpl_h_addr, cpl_h_len, cpl_h_bytes, cpl_h_last}), $sampled(exp_h[31:2]));

    a_h_resp: assert property (@(posedge clk) disable iff (rst)
        (cpl_h_valid && cpl_h_ready && exp_h_ok) |-> (cpl_h_resp == exp_h[1:0]))
        else report_mismatch("cpl_h_resp", $sampled(cpl_h_resp), $sampled(exp_h[1:0]));

    a_credit: assert property (@(posedge clk) disable iff (rst) reserved <= BUF_DW)
        else report_failure($sformatf("%0d dwords issued but not yet popped, more than %0d",
            $sampled(reserved), BUF_DW));

    a_mot: assert property (@(posedge clk) disable iff (rst) outstanding <= MOT_MAX)
        else report_failure($sformatf("%0d bursts outstanding, more than %0d",
            $sampled(outstanding), MOT_MAX));

    a_busy: assert property (@(posedge clk) disable iff (rst) rd_busy == busy_exp)
        else report_mismatch("rd_busy", $sampled(rd_busy), $sampled(busy_exp));

    a_reset_idle: assert property (@(posedge clk) $fell(rst)
        |-> (!rd_busy && !axi_ar_valid && !axi_r_ready && !cpl_h_valid && !cpl_d_valid
             && req_h_ready))
        else report_failure("outputs not idle right after reset");

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d headers and %0d dwords still expected",
                     cycles, hq.size(), dq.size());
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        int base;
        void'($urandom(SEED));
        rst = 1'b1;
        req_h_valid = 1'b0;
        req_h_addr = '0;
        req_h_len = '0;
        cpl_d_ready = 1'b1;
        cpl_h_ready = 1'b1;
        ready_mode = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        base = errors;
        send_req(32'h0000_0000, 16);
        send_req(32'h0000_003C, 5);
        send_req(32'h0000_0104, 40);
        send_req(32'h0000_0200, 1);
        wait_drain();
        report_test("data integrity", base);

        base = errors;
        for (int i = 0; i < N_RANDOM; i++) begin
            send_req(32'($urandom_range(0, 32'h7FF) << 2), $urandom_range(1, 64));
        end
        wait_drain();
        report_test("split and header fields", base);

        base = errors;
        for (int i = 0; i < N_ERR; i++) begin
            send_req(err_addr[i], err_len[i]);
        end
        wait_drain();
        report_test("error merging", base);

        base = errors;
        ready_mode = 1;
        for (int i = 0; i < N_BP; i++) begin
            send_req(32'($urandom_range(0, 32'h7FF) << 2), $urandom_range(1, 64));
        end
        wait_drain();
        ready_mode = 0;
        report_test("back-pressure", base);

        // Data held back until the buffer and burst slots run out
        base = errors;
        ready_mode = 2;
        for (int i = 0; i < N_STALL; i++) begin
            send_req(32'h0000_2000 + 32'(i * 'h100), 64);
        end
        // Buffer fully reserved and nothing in flight
        @(negedge clk);
        while (reserved != BUF_DW || rd_busy) begin
            @(negedge clk);
        end
        repeat (STALL_HOLD) @(posedge clk);
        #1;
        ready_mode = 0;
        wait_drain();
        report_test("outstanding limit and status", base);

        $display("Summary: %0d requests, %0d headers, %0d data beats, %0d errors",
                 reqs_sent, h_checks, d_checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
